//--- source/cnn_macros.svh
`ifndef CNN_MACROS_SVH
`define CNN_MACROS_SVH

// frame geometry
`define CNN_N_FEAT      8
`define CNN_N_STEP      5
`define CNN_N_SAMPLE    (`CNN_N_STEP * `CNN_N_FEAT)

// convolution
`define CNN_N_CHAN      10
`define CNN_N_TAP       3
`define CNN_N_POS       (`CNN_N_STEP - `CNN_N_TAP + 1)
`define CNN_N_KERNEL    (`CNN_N_FEAT * `CNN_N_TAP)
`define CNN_N_FEATURE   (`CNN_N_CHAN * `CNN_N_POS)

// classifier
`define CNN_N_CLASS     27
`define CNN_N_TOP       3

`define CNN_FRAC_SHIFT  8   // bias alignment and result scaling

// weight port address map, one base per region
`define CNN_ADDR_CONV_W 0
`define CNN_ADDR_CONV_B 240
`define CNN_ADDR_FC_W   256
`define CNN_ADDR_FC_B   1072
`define CNN_ADDR_END    1099

`endif

//--- source/cnn_data_pkg.sv
`default_nettype none

package cnn_data_pkg;

    // input sample, already normalized
    typedef logic signed [15:0] sample_t;

    // conv and fc weights and biases share one format
    typedef logic signed [15:0] weight_t;

    // convolution output after shift and clamp
    typedef logic signed [23:0] feature_t;

    typedef logic signed [39:0] conv_acc_t;   // 16x16 products, 24 taps plus bias
    typedef logic signed [47:0] fc_acc_t;     // 24x16 products, 30 terms plus bias

    // class score after the final shift
    typedef logic signed [31:0] logit_t;

    typedef logic [4:0] class_t;              // 0..26, 31 marks an empty rank

    // word address on the shared write port
    typedef logic [10:0] waddr_t;

endpackage

`default_nettype wire

//--- source/cnn_ctrl_pkg.sv
`default_nettype none

package cnn_ctrl_pkg;

    // producer side, conv_wait_bank holds a captured frame until the buffer has room
    typedef enum logic [1:0] {
        conv_idle,
        conv_mac,
        conv_store,
        conv_wait_bank
    } conv_state_t;

    // consumer side
    typedef enum logic [1:0] {
        score_idle,
        score_mac,
        score_rank
    } score_state_t;

endpackage

`default_nettype wire

//--- source/conv_engine.sv
`default_nettype none
`include "cnn_macros.svh"

module conv_engine (
    input  wire                        i_clk,
    input  wire                        i_rst_n,
    input  wire                        i_start,
    input  wire cnn_data_pkg::sample_t i_data [0:`CNN_N_SAMPLE-1],
    input  wire                        i_wr_en,
    input  wire cnn_data_pkg::waddr_t  i_wr_addr,
    input  wire cnn_data_pkg::weight_t i_wr_data,
    input  wire                        i_bank_free,
    output logic                       o_wr_valid,
    output logic [4:0]                 o_wr_index,
    output cnn_data_pkg::feature_t     o_wr_feature,
    output logic                       o_wr_last,
    output logic                       o_busy
);

    cnn_ctrl_pkg::conv_state_t state;

    cnn_data_pkg::sample_t   frame    [0:`CNN_N_SAMPLE-1];
    cnn_data_pkg::weight_t   kern_mem [0:`CNN_N_CHAN*`CNN_N_KERNEL-1];
    cnn_data_pkg::weight_t   bias_mem [0:`CNN_N_CHAN-1];
    cnn_data_pkg::conv_acc_t acc;
    cnn_data_pkg::conv_acc_t acc_shift;
    cnn_data_pkg::conv_acc_t bias_ext;
    cnn_data_pkg::feature_t  result;
    cnn_data_pkg::waddr_t    kern_off;
    cnn_data_pkg::waddr_t    bias_off;

    logic [3:0]         chan;
    logic [1:0]         pos;
    logic [2:0]         feat;
    logic [1:0]         tap;
    logic [5:0]         sample_idx;
    logic [7:0]         kern_idx;
    logic signed [31:0] product;
    logic               first_tap;
    logic               last_feature;
    logic               start_ok;

    // region offsets wrap to large values below the base, so one compare is enough
    assign kern_off = cnn_data_pkg::waddr_t'(i_wr_addr - `CNN_ADDR_CONV_W);
    assign bias_off = cnn_data_pkg::waddr_t'(i_wr_addr - `CNN_ADDR_CONV_B);

    always_ff @(posedge i_clk) begin
        if (i_wr_en && kern_off < `CNN_N_CHAN * `CNN_N_KERNEL) begin
            kern_mem[kern_off[7:0]] <= i_wr_data;
        end
        if (i_wr_en && bias_off < `CNN_N_CHAN) begin
            bias_mem[bias_off[3:0]] <= i_wr_data;
        end
    end

    assign start_ok = i_start && (state == cnn_ctrl_pkg::conv_idle);

    always_ff @(posedge i_clk) begin
        if (start_ok) begin
            frame <= i_data;
        end
    end

    // feature c*3+t reads sample (t+k)*8+f against weight c*24+f*3+k
    assign sample_idx = 6'((pos + tap) * `CNN_N_FEAT + feat);
    assign kern_idx   = 8'(chan * `CNN_N_KERNEL + feat * `CNN_N_TAP + tap);
    assign product    = frame[sample_idx] * kern_mem[kern_idx];
    assign bias_ext   = cnn_data_pkg::conv_acc_t'(bias_mem[chan]) <<< `CNN_FRAC_SHIFT;

    assign first_tap    = (feat == 3'd0) && (tap == 2'd0);
    assign last_feature = (chan == `CNN_N_CHAN - 1) && (pos == `CNN_N_POS - 1);

    always_ff @(posedge i_clk) begin
        if (state == cnn_ctrl_pkg::conv_mac) begin
            acc <= (first_tap ? bias_ext : acc) + cnn_data_pkg::conv_acc_t'(product);
        end
    end

    assign acc_shift = acc >>> `CNN_FRAC_SHIFT;
    assign result    = acc_shift[23:0];

    assign o_wr_valid   = (state == cnn_ctrl_pkg::conv_store);
    assign o_wr_index   = 5'(chan * `CNN_N_POS + pos);
    assign o_wr_feature = result[23] ? '0 : result;   // relu
    assign o_wr_last    = o_wr_valid && last_feature;
    assign o_busy       = (state != cnn_ctrl_pkg::conv_idle);

    always_ff @(posedge i_clk or posedge i_rst_n) begin
        if (i_rst_n) begin
            state <= cnn_ctrl_pkg::conv_idle;
            chan  <= '0;
            pos   <= '0;
            feat  <= '0;
            tap   <= '0;
        end else begin
            case (state)
                cnn_ctrl_pkg::conv_idle: begin
                    if (i_start) begin
                        chan  <= '0;
                        pos   <= '0;
                        feat  <= '0;
                        tap   <= '0;
                        state <= i_bank_free ? cnn_ctrl_pkg::conv_mac
                                             : cnn_ctrl_pkg::conv_wait_bank;
                    end
                end
                cnn_ctrl_pkg::conv_wait_bank: begin
                    if (i_bank_free) begin
                        state <= cnn_ctrl_pkg::conv_mac;
                    end
                end
                cnn_ctrl_pkg::conv_mac: begin
                    if (tap == `CNN_N_TAP - 1) begin
                        tap <= '0;
                        if (feat == `CNN_N_FEAT - 1) begin
                            feat  <= '0;
                            state <= cnn_ctrl_pkg::conv_store;
                        end else begin
                            feat <= feat + 3'd1;
                        end
                    end else begin
                        tap <= tap + 2'd1;
                    end
                end
                cnn_ctrl_pkg::conv_store: begin
                    if (last_feature) begin
                        state <= cnn_ctrl_pkg::conv_idle;   // bank committed by wr_last
                    end else begin
                        state <= cnn_ctrl_pkg::conv_mac;
                        if (pos == `CNN_N_POS - 1) begin
                            pos  <= '0;
                            chan <= chan + 4'd1;
                        end else begin
                            pos <= pos + 2'd1;
                        end
                    end
                end
                default: begin
                    state <= cnn_ctrl_pkg::conv_idle;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- source/feature_buffer.sv
`default_nettype none
`include "cnn_macros.svh"

module feature_buffer (
    input  wire                         i_clk,
    input  wire                         i_rst_n,
    input  wire                         i_wr_valid,
    input  wire [4:0]                   i_wr_index,
    input  wire cnn_data_pkg::feature_t i_wr_feature,
    input  wire                         i_wr_last,
    input  wire [4:0]                   i_rd_index,
    input  wire                         i_rd_release,
    output logic                        o_bank_free,
    output logic                        o_rd_valid,
    output cnn_data_pkg::feature_t      o_rd_feature,
    output logic                        o_busy
);

    cnn_data_pkg::feature_t bank_mem [0:1][0:`CNN_N_FEATURE-1];

    logic       wr_bank;
    logic       rd_bank;
    logic [1:0] n_committed;   // 0..2
    logic       commit;

    assign commit = i_wr_valid && i_wr_last;

    always_ff @(posedge i_clk) begin
        if (i_wr_valid) begin
            bank_mem[wr_bank][i_wr_index] <= i_wr_feature;
        end
    end

    always_ff @(posedge i_clk or posedge i_rst_n) begin
        if (i_rst_n) begin
            wr_bank     <= 1'b0;
            rd_bank     <= 1'b0;
            n_committed <= 2'd0;
        end else begin
            if (commit) begin
                wr_bank <= ~wr_bank;
            end
            if (i_rd_release) begin
                rd_bank <= ~rd_bank;   // release follows commit order
            end
            case ({commit, i_rd_release})
                2'b10:   n_committed <= n_committed + 2'd1;
                2'b01:   n_committed <= n_committed - 2'd1;
                default: n_committed <= n_committed;
            endcase
        end
    end

    // the write bank is never the one being read while a bank is committed
    assign o_bank_free  = (n_committed != 2'd2);
    assign o_rd_valid   = (n_committed != 2'd0);
    assign o_rd_feature = bank_mem[rd_bank][i_rd_index];
    assign o_busy       = (n_committed != 2'd0);

endmodule

`default_nettype wire

//--- source/class_scorer.sv
`default_nettype none
`include "cnn_macros.svh"

module class_scorer (
    input  wire                         i_clk,
    input  wire                         i_rst_n,
    input  wire                         i_rd_valid,
    input  wire cnn_data_pkg::feature_t i_rd_feature,
    input  wire                         i_wr_en,
    input  wire cnn_data_pkg::waddr_t   i_wr_addr,
    input  wire cnn_data_pkg::weight_t  i_wr_data,
    output logic [4:0]                  o_rd_index,
    output logic                        o_rd_release,
    output cnn_data_pkg::class_t        o_char   [0:`CNN_N_TOP-1],
    output cnn_data_pkg::logit_t        o_logits [0:`CNN_N_TOP-1],
    output logic                        o_finished,
    output logic                        o_busy
);

    localparam cnn_data_pkg::logit_t LOGIT_MIN  = {1'b1, {31{1'b0}}};
    localparam cnn_data_pkg::class_t EMPTY_CHAR = 5'd31;

    cnn_ctrl_pkg::score_state_t state;

    cnn_data_pkg::weight_t fc_w [0:`CNN_N_CLASS*`CNN_N_FEATURE-1];
    cnn_data_pkg::weight_t fc_b [0:`CNN_N_CLASS-1];
    cnn_data_pkg::fc_acc_t acc;
    cnn_data_pkg::fc_acc_t acc_shift;
    cnn_data_pkg::fc_acc_t bias_ext;
    cnn_data_pkg::logit_t  logit;
    cnn_data_pkg::waddr_t  fcw_off;
    cnn_data_pkg::waddr_t  fcb_off;

    // working ranking and its update for the class being ranked
    cnn_data_pkg::logit_t top_logit [0:`CNN_N_TOP-1];
    cnn_data_pkg::class_t top_char  [0:`CNN_N_TOP-1];
    cnn_data_pkg::logit_t nxt_logit [0:`CNN_N_TOP-1];
    cnn_data_pkg::class_t nxt_char  [0:`CNN_N_TOP-1];

    logic [4:0]         cls;
    logic [4:0]         feat;
    logic [9:0]         w_idx;
    logic signed [39:0] product;
    logic               last_feat;
    logic               last_class;

    assign fcw_off = cnn_data_pkg::waddr_t'(i_wr_addr - `CNN_ADDR_FC_W);
    assign fcb_off = cnn_data_pkg::waddr_t'(i_wr_addr - `CNN_ADDR_FC_B);

    always_ff @(posedge i_clk) begin
        if (i_wr_en && fcw_off < `CNN_N_CLASS * `CNN_N_FEATURE) begin
            fc_w[fcw_off[9:0]] <= i_wr_data;
        end
        if (i_wr_en && fcb_off < `CNN_ADDR_END - `CNN_ADDR_FC_B) begin
            fc_b[fcb_off[4:0]] <= i_wr_data;
        end
    end

    assign w_idx    = 10'(cls * `CNN_N_FEATURE + feat);
    assign product  = i_rd_feature * fc_w[w_idx];
    assign bias_ext = cnn_data_pkg::fc_acc_t'(fc_b[cls]) <<< `CNN_FRAC_SHIFT;

    assign last_feat  = (feat == `CNN_N_FEATURE - 1);
    assign last_class = (cls == `CNN_N_CLASS - 1);

    always_ff @(posedge i_clk) begin
        if (state == cnn_ctrl_pkg::score_mac) begin
            acc <= ((feat == 5'd0) ? bias_ext : acc) + cnn_data_pkg::fc_acc_t'(product);
        end
    end

    assign acc_shift = acc >>> `CNN_FRAC_SHIFT;
    assign logit     = acc_shift[31:0];

    // insert below any entry that is greater or equal, so ties keep the lower class
    always_comb begin
        nxt_logit = top_logit;
        nxt_char  = top_char;
        if (logit > top_logit[0]) begin
            nxt_logit[2] = top_logit[1];
            nxt_char[2]  = top_char[1];
            nxt_logit[1] = top_logit[0];
            nxt_char[1]  = top_char[0];
            nxt_logit[0] = logit;
            nxt_char[0]  = cls;
        end else if (logit > top_logit[1]) begin
            nxt_logit[2] = top_logit[1];
            nxt_char[2]  = top_char[1];
            nxt_logit[1] = logit;
            nxt_char[1]  = cls;
        end else if (logit > top_logit[2]) begin
            nxt_logit[2] = logit;
            nxt_char[2]  = cls;
        end
    end

    assign o_rd_index   = feat;
    assign o_rd_release = (state == cnn_ctrl_pkg::score_mac) && last_feat && last_class;
    assign o_busy       = (state != cnn_ctrl_pkg::score_idle);

    always_ff @(posedge i_clk or posedge i_rst_n) begin
        if (i_rst_n) begin
            state      <= cnn_ctrl_pkg::score_idle;
            cls        <= '0;
            feat       <= '0;
            top_logit  <= '{default: '0};
            top_char   <= '{default: '0};
            o_logits   <= '{default: '0};
            o_char     <= '{default: '0};
            o_finished <= 1'b0;
        end else begin
            o_finished <= 1'b0;
            case (state)
                cnn_ctrl_pkg::score_idle: begin
                    if (i_rd_valid) begin
                        cls       <= '0;
                        feat      <= '0;
                        top_logit <= '{default: LOGIT_MIN};
                        top_char  <= '{default: EMPTY_CHAR};
                        state     <= cnn_ctrl_pkg::score_mac;
                    end
                end
                cnn_ctrl_pkg::score_mac: begin
                    if (last_feat) begin
                        feat  <= '0;
                        state <= cnn_ctrl_pkg::score_rank;
                    end else begin
                        feat <= feat + 5'd1;
                    end
                end
                cnn_ctrl_pkg::score_rank: begin
                    top_logit <= nxt_logit;
                    top_char  <= nxt_char;
                    if (last_class) begin
                        o_logits   <= nxt_logit;
                        o_char     <= nxt_char;
                        o_finished <= 1'b1;
                        state      <= cnn_ctrl_pkg::score_idle;
                    end else begin
                        cls   <= cls + 5'd1;
                        state <= cnn_ctrl_pkg::score_mac;
                    end
                end
                default: begin
                    state <= cnn_ctrl_pkg::score_idle;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- source/char_classifier.sv
`default_nettype none
`include "cnn_macros.svh"

module char_classifier (
    input  wire                        i_clk,
    input  wire                        i_rst_n,
    input  wire                        i_start,
    input  wire cnn_data_pkg::sample_t i_data [0:`CNN_N_SAMPLE-1],
    input  wire                        i_wr_en,
    input  wire cnn_data_pkg::waddr_t  i_wr_addr,
    input  wire cnn_data_pkg::weight_t i_wr_data,
    output cnn_data_pkg::class_t       o_char   [0:`CNN_N_TOP-1],
    output cnn_data_pkg::logit_t       o_logits [0:`CNN_N_TOP-1],
    output logic                       o_finished,
    output logic                       o_busy
);

    // producer to buffer
    logic                   wr_valid;
    logic [4:0]             wr_index;
    cnn_data_pkg::feature_t wr_feature;
    logic                   wr_last;
    logic                   bank_free;

    // buffer to consumer
    logic                   rd_valid;
    logic [4:0]             rd_index;
    cnn_data_pkg::feature_t rd_feature;
    logic                   rd_release;

    logic conv_busy;
    logic buf_busy;
    logic score_busy;

    // the weight port goes to both engines, each decodes its own regions
    conv_engine u_conv (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_start      (i_start),
        .i_data       (i_data),
        .i_wr_en      (i_wr_en),
        .i_wr_addr    (i_wr_addr),
        .i_wr_data    (i_wr_data),
        .i_bank_free  (bank_free),
        .o_wr_valid   (wr_valid),
        .o_wr_index   (wr_index),
        .o_wr_feature (wr_feature),
        .o_wr_last    (wr_last),
        .o_busy       (conv_busy)
    );

    feature_buffer u_buf (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_wr_valid   (wr_valid),
        .i_wr_index   (wr_index),
        .i_wr_feature (wr_feature),
        .i_wr_last    (wr_last),
        .i_rd_index   (rd_index),
        .i_rd_release (rd_release),
        .o_bank_free  (bank_free),
        .o_rd_valid   (rd_valid),
        .o_rd_feature (rd_feature),
        .o_busy       (buf_busy)
    );

    class_scorer u_score (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_rd_valid   (rd_valid),
        .i_rd_feature (rd_feature),
        .i_wr_en      (i_wr_en),
        .i_wr_addr    (i_wr_addr),
        .i_wr_data    (i_wr_data),
        .o_rd_index   (rd_index),
        .o_rd_release (rd_release),
        .o_char       (o_char),
        .o_logits     (o_logits),
        .o_finished   (o_finished),
        .o_busy       (score_busy)
    );

    assign o_busy = conv_busy | buf_busy | score_busy;   // any frame still in flight

endmodule

`default_nettype wire

//--- dv/cnn_ref_model.svh
`ifndef CNN_REF_MODEL_SVH
`define CNN_REF_MODEL_SVH

// features of frame_data, truncated to 24 bits and clamped at zero
function automatic void model_features();
    longint                 acc;
    cnn_data_pkg::feature_t val;
    for (int c = 0; c < `CNN_N_CHAN; c++) begin
        for (int t = 0; t < `CNN_N_POS; t++) begin
            acc = longint'(conv_b[c]) <<< `CNN_FRAC_SHIFT;
            for (int f = 0; f < `CNN_N_FEAT; f++) begin
                for (int k = 0; k < `CNN_N_TAP; k++) begin
                    acc += longint'(frame_data[(t + k) * `CNN_N_FEAT + f])
                         * longint'(conv_w[c * `CNN_N_KERNEL + f * `CNN_N_TAP + k]);
                end
            end
            val = cnn_data_pkg::feature_t'(acc >>> `CNN_FRAC_SHIFT);
            model_feat[c * `CNN_N_POS + t] = (val < 0) ? '0 : val;
        end
    end
endfunction

// class scores and top three, a new logit only passes an entry it strictly beats
function automatic void model_rank();
    longint               acc;
    cnn_data_pkg::logit_t lg;
    cnn_data_pkg::logit_t best_l [0:`CNN_N_TOP-1];
    cnn_data_pkg::class_t best_c [0:`CNN_N_TOP-1];
    int                   slot;
    for (int r = 0; r < `CNN_N_TOP; r++) begin
        best_l[r] = 32'h8000_0000;
        best_c[r] = 5'd31;
    end
    for (int j = 0; j < `CNN_N_CLASS; j++) begin
        acc = longint'(fc_b[j]) <<< `CNN_FRAC_SHIFT;
        for (int i = 0; i < `CNN_N_FEATURE; i++) begin
            acc += longint'(model_feat[i]) * longint'(fc_w[j * `CNN_N_FEATURE + i]);
        end
        lg   = cnn_data_pkg::logit_t'(acc >>> `CNN_FRAC_SHIFT);
        slot = `CNN_N_TOP;
        for (int r = `CNN_N_TOP - 1; r >= 0; r--) begin
            if (lg > best_l[r]) slot = r;
        end
        for (int r = `CNN_N_TOP - 1; r > slot; r--) begin
            best_l[r] = best_l[r - 1];
            best_c[r] = best_c[r - 1];
        end
        if (slot < `CNN_N_TOP) begin
            best_l[slot] = lg;
            best_c[slot] = cnn_data_pkg::class_t'(j);
        end
    end
    for (int r = 0; r < `CNN_N_TOP; r++) begin
        exp_char_q.push_back(best_c[r]);
        exp_logit_q.push_back(best_l[r]);
    end
endfunction

function automatic void predict_frame();
    model_features();
    model_rank();
endfunction

`endif

//--- dv/tb_char_classifier.sv
`default_nettype none
`include "cnn_macros.svh"

module tb_char_classifier;

    localparam int N_ROWS         = 6;
    localparam int TIMEOUT_CYCLES = (N_ROWS + 2) * 2000;
    localparam int CONV_CYCLES    = `CNN_N_FEATURE * (`CNN_N_KERNEL + 1);   // mac plus store
    localparam int MODE_ZERO      = 0;
    localparam int MODE_CONST     = 1;
    localparam int MODE_RAND      = 2;

    // frame mode and gap to a second start per row (0 means a single start)
    int row_mode [0:N_ROWS-1] = '{MODE_ZERO, MODE_CONST, MODE_RAND, MODE_RAND,
                                  MODE_RAND, MODE_RAND};
    int row_gap  [0:N_ROWS-1] = '{0, 0, 0, 0, 2, CONV_CYCLES + 1};

    logic                   i_clk = 1'b0;
    logic                   i_rst_n;
    logic                   i_start;
    cnn_data_pkg::sample_t  frame_data [0:`CNN_N_SAMPLE-1];
    logic                   i_wr_en;
    cnn_data_pkg::waddr_t   i_wr_addr;
    cnn_data_pkg::weight_t  i_wr_data;
    cnn_data_pkg::class_t   o_char   [0:`CNN_N_TOP-1];
    cnn_data_pkg::logit_t   o_logits [0:`CNN_N_TOP-1];
    logic                   o_finished;
    logic                   o_busy;

    // copy of everything written through the weight port
    cnn_data_pkg::weight_t  conv_w [0:`CNN_N_CHAN*`CNN_N_KERNEL-1];
    cnn_data_pkg::weight_t  conv_b [0:`CNN_N_CHAN-1];
    cnn_data_pkg::weight_t  fc_w   [0:`CNN_N_CLASS*`CNN_N_FEATURE-1];
    cnn_data_pkg::weight_t  fc_b   [0:`CNN_N_CLASS-1];
    cnn_data_pkg::feature_t model_feat [0:`CNN_N_FEATURE-1];

    cnn_data_pkg::class_t   exp_char_q  [$];
    cnn_data_pkg::logit_t   exp_logit_q [$];
    int                     exp_frames  = 0;
    int                     fin_count   = 0;
    int                     cycle_count = 0;

    `include "cnn_ref_model.svh"

    char_classifier i_dut (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_start    (i_start),
        .i_data     (frame_data),
        .i_wr_en    (i_wr_en),
        .i_wr_addr  (i_wr_addr),
        .i_wr_data  (i_wr_data),
        .o_char     (o_char),
        .o_logits   (o_logits),
        .o_finished (o_finished),
        .o_busy     (o_busy)
    );

    always #5 i_clk = ~i_clk;

    always @(posedge i_clk) begin
        cycle_count++;
        if (cycle_count > TIMEOUT_CYCLES) begin
            $display("timeout: no end of run after %0d cycles", TIMEOUT_CYCLES);
            $display("TEST FAILED");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    task automatic check_value(input string name, input logic signed [63:0] got,
                               input logic signed [63:0] exp);
        if (got !== exp) begin
            $display("error at %0t: %s is %0d, expected %0d", $time, name, got, exp);
            $display("TEST FAILED");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    // results are sampled mid-cycle away from the updating edge
    always @(negedge i_clk) begin
        if (o_finished === 1'b1) begin
            if (exp_char_q.size() < `CNN_N_TOP) begin
                $display("o_finished pulsed at %0t with no frame outstanding", $time);
                $display("TEST FAILED");
                $fatal(1, "unexpected result");
            end else begin
                for (int r = 0; r < `CNN_N_TOP; r++) begin
                    check_value($sformatf("o_char[%0d]", r), o_char[r], exp_char_q.pop_front());
                    check_value($sformatf("o_logits[%0d]", r), o_logits[r],
                                exp_logit_q.pop_front());
                end
                fin_count++;
            end
        end
    end

    task automatic next_cycle();
        @(posedge i_clk);
        #1;
    endtask

    function automatic cnn_data_pkg::weight_t rand_weight();
        return cnn_data_pkg::weight_t'(int'($urandom_range(8191)) - 4096);
    endfunction

    function automatic cnn_data_pkg::sample_t rand_sample();
        return cnn_data_pkg::sample_t'(int'($urandom_range(4095)) - 2048);
    endfunction

    task automatic write_weight(input int addr, input cnn_data_pkg::weight_t data);
        i_wr_en   = 1'b1;
        i_wr_addr = cnn_data_pkg::waddr_t'(addr);
        i_wr_data = data;
        next_cycle();
    endtask

    // writes every address of the map including the unused gaps
    task automatic load_weights();
        cnn_data_pkg::weight_t w;
        for (int a = 0; a < `CNN_ADDR_END; a++) begin
            w = rand_weight();
            if (a < `CNN_ADDR_CONV_B) begin
                conv_w[a] = w;
            end else if (a < `CNN_ADDR_CONV_B + `CNN_N_CHAN) begin
                conv_b[a - `CNN_ADDR_CONV_B] = w;
            end else if (a >= `CNN_ADDR_FC_B) begin
                fc_b[a - `CNN_ADDR_FC_B] = w;
            end else if (a >= `CNN_ADDR_FC_W &&
                         a < `CNN_ADDR_FC_W + `CNN_N_CLASS * `CNN_N_FEATURE) begin
                fc_w[a - `CNN_ADDR_FC_W] = w;
            end
            write_weight(a, w);
        end
        write_weight(`CNN_ADDR_END, rand_weight());   // address past the map is dropped
        i_wr_en = 1'b0;
    endtask

    task automatic fill_frame(input int mode);
        for (int i = 0; i < `CNN_N_SAMPLE; i++) begin
            case (mode)
                MODE_ZERO:  frame_data[i] = '0;
                MODE_CONST: frame_data[i] = cnn_data_pkg::sample_t'(300);
                default:    frame_data[i] = rand_sample();
            endcase
        end
    endtask

    task automatic run_row(input int mode, input int gap);
        fill_frame(mode);
        predict_frame();
        exp_frames++;
        i_start = 1'b1;
        next_cycle();
        i_start = 1'b0;
        check_value("o_busy", o_busy, 1);
        if (gap > 0) begin
            repeat (gap - 1) next_cycle();
            fill_frame(MODE_RAND);
            if (gap > CONV_CYCLES) begin   // producer is idle again so this start is taken
                predict_frame();
                exp_frames++;
            end
            i_start = 1'b1;
            next_cycle();
            i_start = 1'b0;
        end
        while (o_busy) next_cycle();
        next_cycle();
        check_value("finished count", fin_count, exp_frames);
    endtask

    initial begin
        void'($urandom(32));
        i_rst_n   = 1'b1;
        i_start   = 1'b0;
        i_wr_en   = 1'b0;
        i_wr_addr = '0;
        i_wr_data = '0;
        fill_frame(MODE_ZERO);
        repeat (2) @(posedge i_clk);
        #1;
        i_rst_n = 1'b0;
        next_cycle();
        check_value("o_finished", o_finished, 0);
        check_value("o_busy", o_busy, 0);
        for (int r = 0; r < `CNN_N_TOP; r++) begin
            check_value($sformatf("o_char[%0d]", r), o_char[r], 0);
            check_value($sformatf("o_logits[%0d]", r), o_logits[r], 0);
        end
        load_weights();
        for (int row = 0; row < N_ROWS; row++) begin
            run_row(row_mode[row], row_gap[row]);
        end
        load_weights();   // reload with new weights before one more frame
        run_row(MODE_RAND, 0);
        if (exp_char_q.size() == 0 && fin_count == exp_frames) begin
            $display("TEST OK");
            $finish;
        end else begin
            $display("results missing: %0d frames finished, %0d expected",
                     fin_count, exp_frames);
            $display("TEST FAILED");
            $fatal(1, "run ended with results outstanding");
        end
    end

endmodule

`default_nettype wire

//--- sources.f
+incdir+source
+incdir+dv
source/cnn_data_pkg.sv
source/cnn_ctrl_pkg.sv
source/conv_engine.sv
source/feature_buffer.sv
source/class_scorer.sv
source/char_classifier.sv
dv/tb_char_classifier.sv

//--- Bender.yml
package:
  name: char_classifier

sources:
  - include_dirs:
      - source
    files:
      - source/cnn_data_pkg.sv
      - source/cnn_ctrl_pkg.sv
      - source/conv_engine.sv
      - source/feature_buffer.sv
      - source/class_scorer.sv
      - source/char_classifier.sv
  - target: simulation
    include_dirs:
      - source
      - dv
    files:
      - dv/tb_char_classifier.sv
